/* vlog.f */
ctrl_pkg.sv
exc_sequencer.sv
tick_timer.sv
pic_unit.sv
sys_sprs.sv
ctrl_unit.sv
ctrl_props.sv
ctrl_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the control block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module ctrl_tb -Mdir obj_dir -o ctrl_sim
./obj_dir/ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   exit 0
fi
exit 1

/* ctrl_tb.sv */
/*
 Directed testbench for the exception and SPR control block.
 Covers SPR access, exception entry under fetch back-pressure, priority,
 return from exception, the tick timer and the interrupt controller.
 Top module is ctrl_tb, the DUT is ctrl_unit.
*/
`timescale 1ns/1ps

module ctrl_tb;

   localparam int CLK_PERIOD  = 100;
   localparam int NUM_TESTS   = 6;
   localparam int TICK_PERIOD = 20;
   // Writable SR bits are SM, TEE, IEE, F and CY
   localparam logic [15:0] SR_WMASK  = 16'h0607;
   localparam logic [31:0] EVBA_MASK = 32'hFFFF_E000;

   logic                              clk;
   logic                              rst;
   ctrl_pkg::spr_req_t                spr_req_i;
   ctrl_pkg::exc_t                    exc_i;
   logic [31:0]                       irq_i;
   logic                              fetch_branch_taken_i;
   ctrl_pkg::branch_t                 branch_o;
   logic                              pipeline_flush_o;
   logic [ctrl_pkg::DATA_W-1:0]       spr_rdata_o;
   logic                              spr_rvalid_o;
   logic [ctrl_pkg::SR_W-1:0]         sr_o;

   string       test_name;
   int          errors = 0;
   int          checks = 0;
   int          tests_done = 0;
   int          err_mark = 0;
   logic [31:0] rng_state = 32'd61605;
   logic [15:0] sr_model = 16'h8001;
   logic [31:0] evba_model = 32'h0;

   ctrl_unit u_dut (
      .clk (clk), .rst (rst), .spr_req_i (spr_req_i), .exc_i (exc_i), .irq_i (irq_i),
      .fetch_branch_taken_i (fetch_branch_taken_i), .branch_o (branch_o),
      .pipeline_flush_o (pipeline_flush_o), .spr_rdata_o (spr_rdata_o),
      .spr_rvalid_o (spr_rvalid_o), .sr_o (sr_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // SR after exception entry
   function automatic logic [15:0] entry_sr(input logic [15:0] s);
      return (s | 16'h0001) & ~16'h0006;
   endfunction

   task automatic check_data(input logic [ctrl_pkg::DATA_W-1:0] exp,
                             input logic [ctrl_pkg::DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("MISMATCH %s: expected %h, actual %h", test_name, exp, act);
         errors++;
      end
   endtask

   task automatic check_sr(input logic [ctrl_pkg::SR_W-1:0] exp,
                           input logic [ctrl_pkg::SR_W-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("MISMATCH %s: expected SR %h, actual SR %h", test_name, exp, act);
         errors++;
      end
   endtask

   task automatic check_branch(input ctrl_pkg::branch_t exp, input ctrl_pkg::branch_t act);
      checks++;
      if (act !== exp) begin
         $display("MISMATCH %s: expected valid=%b pc=%h, actual valid=%b pc=%h",
                  test_name, exp.valid, exp.pc, act.valid, act.pc);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = errors;
   endtask

   task automatic end_test();
      tests_done++;
      if (errors == err_mark)
         $display("%s: ok", test_name);
      else
         $display("%s: FAILED with %0d errors", test_name, errors - err_mark);
   endtask

   // All drive tasks start and end 5 ns after a rising edge
   task automatic write_spr(input logic [15:0] addr, input logic [31:0] data);
      spr_req_i          = '0;
      spr_req_i.valid    = 1'b1;
      spr_req_i.we       = 1'b1;
      spr_req_i.addr.raw = addr;
      spr_req_i.wdata    = data;
      @(posedge clk);
      #5;
      spr_req_i = '0;
   endtask

   task automatic write_sr(input logic [15:0] w);
      write_spr(ctrl_pkg::ADDR_SR, {16'h0000, w});
      sr_model = (sr_model & ~SR_WMASK) | (w & SR_WMASK);
   endtask

   task automatic read_spr(input logic [15:0] addr, input logic [31:0] exp);
      spr_req_i          = '0;
      spr_req_i.valid    = 1'b1;
      spr_req_i.addr.raw = addr;
      @(posedge clk);
      #5;
      spr_req_i = '0;
      if (!spr_rvalid_o) begin
         $display("ERROR %s: no read data one cycle after the request to %h", test_name, addr);
         errors++;
      end
      check_data(exp, spr_rdata_o);
   endtask

   task automatic raise_flush(input ctrl_pkg::exc_t e, input logic rfe);
      exc_i           = e;
      spr_req_i       = '0;
      spr_req_i.valid = rfe;
      spr_req_i.rfe   = rfe;
      #1;
      if (!pipeline_flush_o) begin
         $display("ERROR %s: pipeline flush not raised in the accepting cycle", test_name);
         errors++;
      end
      @(posedge clk);
      #5;
      exc_i     = '0;
      spr_req_i = '0;
   endtask

   // Holds off fetch for a random number of cycles, then takes the branch
   task automatic wait_branch(input logic [31:0] exp_pc);
      ctrl_pkg::branch_t exp_br;
      int                waited;
      int                hold;
      waited       = 0;
      exp_br.valid = 1'b1;
      exp_br.pc    = exp_pc;
      while (!branch_o.valid && waited < 50) begin
         @(posedge clk);
         #5;
         waited++;
      end
      if (!branch_o.valid) begin
         $display("ERROR %s: no branch request after %0d cycles", test_name, waited);
         errors++;
      end else begin
         check_branch(exp_br, branch_o);
         hold = 1 + int'(xorshift() % 32'd6);
         repeat (hold) begin
            @(posedge clk);
            #5;
         end
         check_branch(exp_br, branch_o);
         fetch_branch_taken_i = 1'b1;
         @(posedge clk);
         #5;
         fetch_branch_taken_i = 1'b0;
         if (branch_o.valid) begin
            $display("ERROR %s: branch request still valid after fetch took it", test_name);
            errors++;
         end
         // One settle cycle before requests are accepted again
         @(posedge clk);
         #5;
      end
   endtask

   task automatic spr_round_trip();
      begin_test("spr_round_trip");
      if (branch_o.valid || pipeline_flush_o || spr_rvalid_o) begin
         $display("ERROR %s: control outputs not low after reset", test_name);
         errors++;
      end
      check_sr(16'h8001, sr_o);
      read_spr(ctrl_pkg::ADDR_PICMR, 32'h0);
      read_spr(ctrl_pkg::ADDR_TTMR, 32'h0);
      read_spr(ctrl_pkg::ADDR_TTCR, 32'h0);
      write_spr(ctrl_pkg::ADDR_EVBA, 32'hFFFF_FFFF);
      read_spr(ctrl_pkg::ADDR_EVBA, 32'hFFFF_E000);
      write_spr(ctrl_pkg::ADDR_PICMR, 32'h5A5A_0F0F);
      read_spr(ctrl_pkg::ADDR_PICMR, 32'h5A5A_0F0F);
      write_spr(ctrl_pkg::ADDR_TTMR, 32'h0ABC_DEF0);
      read_spr(ctrl_pkg::ADDR_TTMR, 32'h0ABC_DEF0);
      write_spr(16'h0777, 32'h1234_5678);
      read_spr(16'h0777, 32'h0);
      end_test();
   endtask

   task automatic syscall_backpressure();
      ctrl_pkg::exc_t e;
      logic [15:0]    old_sr;
      begin_test("syscall_backpressure");
      write_spr(ctrl_pkg::ADDR_EVBA, 32'h1234_5678);
      evba_model = 32'h1234_5678 & EVBA_MASK;
      write_sr(16'h0607);
      old_sr = sr_model;
      e      = '0;
      e.syscall = 1'b1;
      e.pc      = 32'h0000_2100;
      raise_flush(e, 1'b0);
      wait_branch(evba_model | 32'h0000_0C00);
      sr_model = entry_sr(old_sr);
      check_sr(sr_model, sr_o);
      read_spr(ctrl_pkg::ADDR_EPCR, 32'h0000_2104);
      read_spr(ctrl_pkg::ADDR_ESR, {16'h0000, old_sr});
      read_spr(ctrl_pkg::ADDR_SR, {16'h0000, sr_model});
      end_test();
   endtask

   task automatic priority_and_eear();
      ctrl_pkg::exc_t e;
      begin_test("priority_and_eear");
      e         = '0;
      e.illegal = 1'b1;
      e.trap    = 1'b1;
      e.pc      = 32'h0000_3300;
      raise_flush(e, 1'b0);
      wait_branch(evba_model | 32'h0000_0700);
      sr_model = entry_sr(sr_model);
      read_spr(ctrl_pkg::ADDR_EPCR, 32'h0000_3300);
      e       = '0;
      e.align = 1'b1;
      e.pc    = 32'h0000_3400;
      e.ea    = 32'h0000_5003;
      raise_flush(e, 1'b0);
      wait_branch(evba_model | 32'h0000_0600);
      read_spr(ctrl_pkg::ADDR_EEAR, 32'h0000_5003);
      read_spr(ctrl_pkg::ADDR_EPCR, 32'h0000_3400);
      check_sr(sr_model, sr_o);
      end_test();
   endtask

   task automatic return_from_exception();
      begin_test("return_from_exception");
      write_spr(ctrl_pkg::ADDR_ESR, 32'h0000_8201);
      write_spr(ctrl_pkg::ADDR_EPCR, 32'h0000_4A40);
      raise_flush('0, 1'b1);
      wait_branch(32'h0000_4A40);
      sr_model = 16'h8201;
      check_sr(sr_model, sr_o);
      read_spr(ctrl_pkg::ADDR_SR, {16'h0000, sr_model});
      end_test();
   endtask

   task automatic tick_one_shot();
      begin_test("tick_one_shot");
      write_spr(ctrl_pkg::ADDR_TTCR, 32'h0);
      // One-shot mode with IE set
      write_spr(ctrl_pkg::ADDR_TTMR, 32'hA000_0000 | TICK_PERIOD);
      repeat (TICK_PERIOD + 4) begin
         @(posedge clk);
         #5;
      end
      read_spr(ctrl_pkg::ADDR_TTCR, TICK_PERIOD);
      read_spr(ctrl_pkg::ADDR_TTMR, 32'hB000_0000 | TICK_PERIOD);
      write_sr(sr_model | 16'h0002);
      wait_branch(evba_model | 32'h0000_0500);
      sr_model = entry_sr(sr_model);
      check_sr(sr_model, sr_o);
      write_spr(ctrl_pkg::ADDR_TTMR, 32'h0);
      end_test();
   endtask

   task automatic pic_masking();
      begin_test("pic_masking");
      write_spr(ctrl_pkg::ADDR_PICMR, ~32'h0000_0020);
      write_sr(sr_model | 16'h0004);
      irq_i = 32'h0000_0020;
      repeat (5) begin
         @(posedge clk);
         #5;
         if (branch_o.valid || pipeline_flush_o) begin
            $display("ERROR %s: interrupt taken with its mask bit clear", test_name);
            errors++;
         end
      end
      read_spr(ctrl_pkg::ADDR_PICSR, 32'h0);
      // Unmask with IEE off so the status can be read first
      write_sr(sr_model & ~16'h0004);
      write_spr(ctrl_pkg::ADDR_PICMR, 32'h0000_0020);
      read_spr(ctrl_pkg::ADDR_PICSR, 32'h0000_0020);
      write_sr(sr_model | 16'h0004);
      wait_branch(evba_model | 32'h0000_0800);
      sr_model = entry_sr(sr_model);
      check_sr(sr_model, sr_o);
      irq_i = '0;
      write_spr(ctrl_pkg::ADDR_PICMR, 32'h0);
      end_test();
   endtask

   initial begin
      clk                  = 1'b0;
      rst                  = 1'b1;
      spr_req_i            = '0;
      exc_i                = '0;
      irq_i                = '0;
      fetch_branch_taken_i = 1'b0;
      repeat (16) @(posedge clk);
      #5;
      rst = 1'b0;
      spr_round_trip();
      syscall_backpressure();
      priority_and_eear();
      return_from_exception();
      tick_one_shot();
      pic_masking();
      $display("Tests run: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Watchdog sized from the number of tests
   initial begin
      #((NUM_TESTS * 200 + 16) * CLK_PERIOD);
      $display("ERROR watchdog: run did not finish within %0d cycles", NUM_TESTS * 200 + 16);
      $display("Test failures found");
      $finish;
   end

endmodule

/* ctrl_props.sv */
/*
 Concurrent checks bound to every exc_sequencer instance.
 Covers the branch handshake, the take pulse and SR after entry.
*/
`timescale 1ns/1ps

module ctrl_props (
   input logic                      clk,
   input logic                      rst,
   input logic                      take_i,
   input logic                      fetch_branch_taken_i,
   input ctrl_pkg::branch_t         branch_i,
   input logic [ctrl_pkg::SR_W-1:0] sr_i
);

   // Request stays up with a stable pc until fetch takes it
   a_branch_hold: assert property (@(posedge clk) disable iff (rst)
      branch_i.valid && !fetch_branch_taken_i |=> branch_i.valid && $stable(branch_i.pc))
      else $error("branch request dropped or changed before fetch took it");

   a_take_pulse: assert property (@(posedge clk) disable iff (rst)
      take_i |=> !take_i)
      else $error("take held for more than one cycle");

   // Supervisor mode with interrupts off after entry
   a_sr_entry: assert property (@(posedge clk) disable iff (rst)
      take_i |=> sr_i[ctrl_pkg::SR_SM] && !sr_i[ctrl_pkg::SR_IEE])
      else $error("SR not in supervisor mode with IEE clear after exception entry");

endmodule

bind exc_sequencer ctrl_props u_props (
   .clk (clk), .rst (rst), .take_i (take_o), .fetch_branch_taken_i (fetch_branch_taken_i),
   .branch_i (branch_o), .sr_i (sr_i)
);

/* ctrl_unit.sv */
/*
 Top of the exception and SPR control block.
 Connects the sequencer, tick timer, interrupt controller and
 system registers to the execute and fetch stage ports.
*/
`timescale 1ns/1ps

module ctrl_unit (
   input  logic                        clk,
   input  logic                        rst,
   input  ctrl_pkg::spr_req_t          spr_req_i,
   input  ctrl_pkg::exc_t              exc_i,
   input  logic [31:0]                 irq_i,
   input  logic                        fetch_branch_taken_i,
   output ctrl_pkg::branch_t           branch_o,
   output logic                        pipeline_flush_o,
   output logic [ctrl_pkg::DATA_W-1:0] spr_rdata_o,
   output logic                        spr_rvalid_o,
   output logic [ctrl_pkg::SR_W-1:0]   sr_o
);

   ctrl_pkg::exc_cause_t        cause;
   logic                        take;
   logic                        rfe_take;
   logic                        idle;
   logic                        unit_we;
   logic                        tick_irq;
   logic                        pic_irq;
   logic [ctrl_pkg::DATA_W-1:0] target;
   logic [ctrl_pkg::DATA_W-1:0] tick_rdata;
   logic [ctrl_pkg::DATA_W-1:0] pic_rdata;

   exc_sequencer u_seq (
      .clk (clk), .rst (rst), .exc_i (exc_i),
      .rfe_i (spr_req_i.valid & spr_req_i.rfe),
      .tick_irq_i (tick_irq), .pic_irq_i (pic_irq), .sr_i (sr_o),
      .fetch_branch_taken_i (fetch_branch_taken_i), .target_i (target),
      .cause_o (cause), .take_o (take), .rfe_take_o (rfe_take), .idle_o (idle),
      .branch_o (branch_o), .pipeline_flush_o (pipeline_flush_o)
   );

   tick_timer u_tick (
      .clk (clk), .rst (rst), .we_i (unit_we), .addr_i (spr_req_i.addr),
      .wdata_i (spr_req_i.wdata), .rdata_o (tick_rdata), .irq_o (tick_irq)
   );

   pic_unit u_pic (
      .clk (clk), .rst (rst), .we_i (unit_we), .addr_i (spr_req_i.addr),
      .wdata_i (spr_req_i.wdata), .irq_i (irq_i), .rdata_o (pic_rdata), .irq_o (pic_irq)
   );

   sys_sprs u_sprs (
      .clk (clk), .rst (rst), .req_i (spr_req_i), .idle_i (idle), .exc_i (exc_i),
      .cause_i (cause), .take_i (take), .rfe_take_i (rfe_take),
      .pic_rdata_i (pic_rdata), .tick_rdata_i (tick_rdata), .target_o (target),
      .unit_we_o (unit_we), .sr_o (sr_o), .rdata_o (spr_rdata_o), .rvalid_o (spr_rvalid_o)
   );

endmodule

/* sys_sprs.sv */
/*
 System group SPRs SR, ESR, EPCR, EEAR and EVBA.
 Saves state on exception entry, restores SR on rfe, builds the
 branch target and returns SPR read data one cycle after a request.
*/
`timescale 1ns/1ps

module sys_sprs (
   input  logic                        clk,
   input  logic                        rst,
   input  ctrl_pkg::spr_req_t          req_i,
   input  logic                        idle_i,
   input  ctrl_pkg::exc_t              exc_i,
   input  ctrl_pkg::exc_cause_t        cause_i,
   input  logic                        take_i,
   input  logic                        rfe_take_i,
   input  logic [ctrl_pkg::DATA_W-1:0] pic_rdata_i,
   input  logic [ctrl_pkg::DATA_W-1:0] tick_rdata_i,
   output logic [ctrl_pkg::DATA_W-1:0] target_o,
   output logic                        unit_we_o,
   output logic [ctrl_pkg::SR_W-1:0]   sr_o,
   output logic [ctrl_pkg::DATA_W-1:0] rdata_o,
   output logic                        rvalid_o
);

   logic [ctrl_pkg::SR_W-1:0]   sr_q;
   logic [ctrl_pkg::SR_W-1:0]   esr_q;
   logic [ctrl_pkg::DATA_W-1:0] epcr_q;
   logic [ctrl_pkg::DATA_W-1:0] eear_q;
   logic [ctrl_pkg::DATA_W-1:0] evba_q;
   logic [ctrl_pkg::DATA_W-1:0] rd_mux;
   logic [ctrl_pkg::DATA_W-1:0] rdata_q;
   logic                        rvalid_q;
   logic [11:0]                 vec;
   logic                        access;
   logic                        wr;
   logic                        rd;
   logic                        next_pc_save;

   // Requests only go through in IDLE and lose against an exception
   assign access    = req_i.valid & ~req_i.rfe & idle_i & ~take_i;
   assign wr        = access & req_i.we;
   assign rd        = access & ~req_i.we;
   assign unit_we_o = wr;

   // These causes resume after the faulting instruction
   assign next_pc_save = (cause_i == ctrl_pkg::SYSCALL) | (cause_i == ctrl_pkg::INT) |
                         (cause_i == ctrl_pkg::TICK);

   always_ff @(posedge clk) begin
      if (rst) begin
         sr_q  <= ctrl_pkg::SR_RESET;
         esr_q <= ctrl_pkg::SR_RESET;
      end else if (take_i) begin
         esr_q                   <= sr_q;
         sr_q[ctrl_pkg::SR_SM]   <= 1'b1;
         sr_q[ctrl_pkg::SR_IEE]  <= 1'b0;
         sr_q[ctrl_pkg::SR_TEE]  <= 1'b0;
      end else if (rfe_take_i) begin
         sr_q <= esr_q;
      end else if (wr && req_i.addr.raw == ctrl_pkg::ADDR_SR) begin
         sr_q <= (sr_q & ~ctrl_pkg::SR_WMASK) |
                 (req_i.wdata[ctrl_pkg::SR_W-1:0] & ctrl_pkg::SR_WMASK);
      end else if (wr && req_i.addr.raw == ctrl_pkg::ADDR_ESR) begin
         esr_q <= req_i.wdata[ctrl_pkg::SR_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (take_i) begin
         epcr_q <= next_pc_save ? exc_i.pc + ctrl_pkg::DATA_W'(4) : exc_i.pc;
         eear_q <= (cause_i == ctrl_pkg::ALIGN) ? exc_i.ea : exc_i.pc;
      end else if (wr && req_i.addr.raw == ctrl_pkg::ADDR_EPCR) begin
         epcr_q <= req_i.wdata;
      end else if (wr && req_i.addr.raw == ctrl_pkg::ADDR_EEAR) begin
         eear_q <= req_i.wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst)
         evba_q <= '0;
      else if (wr && req_i.addr.raw == ctrl_pkg::ADDR_EVBA)
         evba_q <= {req_i.wdata[ctrl_pkg::DATA_W-1:ctrl_pkg::EVBA_LOW],
                    {ctrl_pkg::EVBA_LOW{1'b0}}};
   end

   always_comb begin
      case (cause_i)
         ctrl_pkg::ILLEGAL: vec = ctrl_pkg::VEC_ILLEGAL;
         ctrl_pkg::ALIGN:   vec = ctrl_pkg::VEC_ALIGN;
         ctrl_pkg::SYSCALL: vec = ctrl_pkg::VEC_SYSCALL;
         ctrl_pkg::TRAP:    vec = ctrl_pkg::VEC_TRAP;
         ctrl_pkg::INT:     vec = ctrl_pkg::VEC_INT;
         ctrl_pkg::TICK:    vec = ctrl_pkg::VEC_TT;
         default:           vec = 12'h000;
      endcase
   end

   assign target_o = rfe_take_i ? epcr_q : evba_q | {{(ctrl_pkg::DATA_W-12){1'b0}}, vec};

   // Unit select by group, then register by full address
   always_comb begin
      case (req_i.addr.fld.grp)
         ctrl_pkg::GRP_SYS: begin
            case (req_i.addr.raw)
               ctrl_pkg::ADDR_SR:   rd_mux = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, sr_q};
               ctrl_pkg::ADDR_ESR:  rd_mux = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, esr_q};
               ctrl_pkg::ADDR_EPCR: rd_mux = epcr_q;
               ctrl_pkg::ADDR_EEAR: rd_mux = eear_q;
               ctrl_pkg::ADDR_EVBA: rd_mux = evba_q;
               default:             rd_mux = '0;
            endcase
         end
         ctrl_pkg::GRP_PIC:  rd_mux = pic_rdata_i;
         ctrl_pkg::GRP_TICK: rd_mux = tick_rdata_i;
         default:            rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         rvalid_q <= 1'b0;
      else
         rvalid_q <= rd;
   end

   always_ff @(posedge clk) begin
      if (rd)
         rdata_q <= rd_mux;
   end

   assign sr_o     = sr_q;
   assign rdata_o  = rdata_q;
   assign rvalid_o = rvalid_q;

endmodule

/* pic_unit.sv */
/*
 Level-triggered interrupt controller.
 PICMR masks the incoming lines, PICSR shows the masked lines
 and any set bit raises the interrupt request.
*/
`timescale 1ns/1ps

module pic_unit (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        we_i,
   input  ctrl_pkg::spr_addr_u         addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] wdata_i,
   input  logic [31:0]                 irq_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdata_o,
   output logic                        irq_o
);

   logic [31:0] picmr_q;
   logic [31:0] picsr;

   always_ff @(posedge clk) begin
      if (rst)
         picmr_q <= '0;
      else if (we_i && addr_i.raw == ctrl_pkg::ADDR_PICMR)
         picmr_q <= wdata_i;
   end

   // Status follows the lines directly, writes have no effect
   assign picsr = irq_i & picmr_q;

   always_comb begin
      case (addr_i.raw)
         ctrl_pkg::ADDR_PICMR: rdata_o = picmr_q;
         ctrl_pkg::ADDR_PICSR: rdata_o = picsr;
         default:              rdata_o = '0;
      endcase
   end

   assign irq_o = |picsr;

endmodule

/* tick_timer.sv */
/*
 Tick timer with TTMR and TTCR.
 TTCR counts one per cycle while the mode is not off, and a match
 against the TTMR period sets the pending bit when IE is set.
*/
`timescale 1ns/1ps

module tick_timer (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        we_i,
   input  ctrl_pkg::spr_addr_u         addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] wdata_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdata_o,
   output logic                        irq_o
);

   logic [ctrl_pkg::DATA_W-1:0] ttmr_q;
   logic [ctrl_pkg::DATA_W-1:0] ttcr_q;
   logic [1:0]                  mode;
   logic                        match;
   logic                        ttmr_we;
   logic                        ttcr_we;

   assign mode    = ttmr_q[ctrl_pkg::TT_MODE_HI:ctrl_pkg::TT_MODE_LO];
   assign match   = ttcr_q[ctrl_pkg::TT_PERIOD_W-1:0] == ttmr_q[ctrl_pkg::TT_PERIOD_W-1:0];
   assign ttmr_we = we_i & (addr_i.raw == ctrl_pkg::ADDR_TTMR);
   assign ttcr_we = we_i & (addr_i.raw == ctrl_pkg::ADDR_TTCR);

   // Mode register, a write replaces IP as well
   always_ff @(posedge clk) begin
      if (rst)
         ttmr_q <= '0;
      else if (ttmr_we)
         ttmr_q <= wdata_i;
      else if (match && mode != ctrl_pkg::TT_OFF && ttmr_q[ctrl_pkg::TT_IE])
         ttmr_q[ctrl_pkg::TT_IP] <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ttcr_q <= '0;
      end else if (ttcr_we) begin
         ttcr_q <= wdata_i;
      end else begin
         case (mode)
            ctrl_pkg::TT_RESTART: ttcr_q <= match ? '0 : ttcr_q + 1'b1;
            // One-shot parks on the match value
            ctrl_pkg::TT_ONESHOT: ttcr_q <= match ? ttcr_q : ttcr_q + 1'b1;
            ctrl_pkg::TT_CONT:    ttcr_q <= ttcr_q + 1'b1;
            default:              ttcr_q <= ttcr_q;
         endcase
      end
   end

   always_comb begin
      case (addr_i.raw)
         ctrl_pkg::ADDR_TTMR: rdata_o = ttmr_q;
         ctrl_pkg::ADDR_TTCR: rdata_o = ttcr_q;
         default:             rdata_o = '0;
      endcase
   end

   assign irq_o = ttmr_q[ctrl_pkg::TT_IP];

endmodule

/* exc_sequencer.sv */
/*
 Exception and return sequencer.
 Picks the highest priority cause in IDLE, pulses take or rfe_take,
 then holds the branch request to fetch until it is taken.
*/
`timescale 1ns/1ps

module exc_sequencer (
   input  logic                        clk,
   input  logic                        rst,
   input  ctrl_pkg::exc_t              exc_i,
   input  logic                        rfe_i,
   input  logic                        tick_irq_i,
   input  logic                        pic_irq_i,
   input  logic [ctrl_pkg::SR_W-1:0]   sr_i,
   input  logic                        fetch_branch_taken_i,
   input  logic [ctrl_pkg::DATA_W-1:0] target_i,
   output ctrl_pkg::exc_cause_t        cause_o,
   output logic                        take_o,
   output logic                        rfe_take_o,
   output logic                        idle_o,
   output ctrl_pkg::branch_t           branch_o,
   output logic                        pipeline_flush_o
);

   ctrl_pkg::seq_state_t        state_q;
   logic                        branch_valid_q;
   logic [ctrl_pkg::DATA_W-1:0] branch_pc_q;
   logic                        int_req;
   logic                        tick_req;

   // Interrupts only count when enabled in SR
   assign int_req  = pic_irq_i & sr_i[ctrl_pkg::SR_IEE];
   assign tick_req = tick_irq_i & sr_i[ctrl_pkg::SR_TEE];

   always_comb begin
      if (exc_i.illegal)
         cause_o = ctrl_pkg::ILLEGAL;
      else if (exc_i.align)
         cause_o = ctrl_pkg::ALIGN;
      else if (exc_i.syscall)
         cause_o = ctrl_pkg::SYSCALL;
      else if (exc_i.trap)
         cause_o = ctrl_pkg::TRAP;
      else if (int_req)
         cause_o = ctrl_pkg::INT;
      else if (tick_req)
         cause_o = ctrl_pkg::TICK;
      else
         cause_o = ctrl_pkg::NONE;
   end

   assign idle_o           = (state_q == ctrl_pkg::IDLE);
   assign take_o           = idle_o & (cause_o != ctrl_pkg::NONE);
   // An exception in the same cycle wins over rfe
   assign rfe_take_o       = idle_o & rfe_i & (cause_o == ctrl_pkg::NONE);
   assign pipeline_flush_o = take_o | rfe_take_o;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q        <= ctrl_pkg::IDLE;
         branch_valid_q <= 1'b0;
      end else begin
         case (state_q)
            ctrl_pkg::IDLE: begin
               if (pipeline_flush_o) begin
                  state_q        <= ctrl_pkg::BRANCH;
                  branch_valid_q <= 1'b1;
               end
            end
            ctrl_pkg::BRANCH: begin
               // Hold under back-pressure
               if (fetch_branch_taken_i) begin
                  state_q        <= ctrl_pkg::SETTLE;
                  branch_valid_q <= 1'b0;
               end
            end
            default: state_q <= ctrl_pkg::IDLE;
         endcase
      end
   end

   // Target is only sampled on acceptance, so pc stays stable in BRANCH
   always_ff @(posedge clk) begin
      if (pipeline_flush_o)
         branch_pc_q <= target_i;
   end

   assign branch_o = '{valid: branch_valid_q, pc: branch_pc_q};

endmodule

/* ctrl_pkg.sv */
/*
 Shared definitions for the exception and SPR control block.
 SPR addresses, exception vectors, SR and tick timer bit positions,
 and the packed types that travel between the control modules.
 Referenced by scoped names from every design file.
*/
package ctrl_pkg;

   localparam int DATA_W = 32;
   localparam int SR_W   = 16;

   // Status register layout
   localparam int SR_SM  = 0;
   localparam int SR_TEE = 1;
   localparam int SR_IEE = 2;
   localparam int SR_F   = 9;
   localparam int SR_CY  = 10;
   localparam logic [SR_W-1:0] SR_RESET = 16'h8001;
   localparam logic [SR_W-1:0] SR_WMASK = (SR_W'(1) << SR_SM) | (SR_W'(1) << SR_TEE) |
                                          (SR_W'(1) << SR_IEE) | (SR_W'(1) << SR_F) |
                                          (SR_W'(1) << SR_CY);

   // SPR addresses
   localparam logic [15:0] ADDR_SR    = 16'h0011;
   localparam logic [15:0] ADDR_EVBA  = 16'h000B;
   localparam logic [15:0] ADDR_EPCR  = 16'h0020;
   localparam logic [15:0] ADDR_EEAR  = 16'h0030;
   localparam logic [15:0] ADDR_ESR   = 16'h0040;
   localparam logic [15:0] ADDR_PICMR = 16'h4800;
   localparam logic [15:0] ADDR_PICSR = 16'h4802;
   localparam logic [15:0] ADDR_TTMR  = 16'h5000;
   localparam logic [15:0] ADDR_TTCR  = 16'h5001;

   localparam logic [4:0] GRP_SYS  = 5'd0;
   localparam logic [4:0] GRP_PIC  = 5'd9;
   localparam logic [4:0] GRP_TICK = 5'd10;

   // Vector offsets, ORed onto EVBA
   localparam logic [11:0] VEC_TT      = 12'h500;
   localparam logic [11:0] VEC_ALIGN   = 12'h600;
   localparam logic [11:0] VEC_ILLEGAL = 12'h700;
   localparam logic [11:0] VEC_INT     = 12'h800;
   localparam logic [11:0] VEC_SYSCALL = 12'hC00;
   localparam logic [11:0] VEC_TRAP    = 12'hE00;

   localparam int EVBA_LOW = 13;

   // Tick timer mode register fields
   localparam int TT_PERIOD_W = 28;
   localparam int TT_IP       = 28;
   localparam int TT_IE       = 29;
   localparam int TT_MODE_LO  = 30;
   localparam int TT_MODE_HI  = 31;
   localparam logic [1:0] TT_OFF     = 2'd0;
   localparam logic [1:0] TT_RESTART = 2'd1;
   localparam logic [1:0] TT_ONESHOT = 2'd2;
   localparam logic [1:0] TT_CONT    = 2'd3;

   typedef struct packed {
      logic [4:0]  grp;
      logic [10:0] idx;
   } spr_field_t;

   // Same address word, seen raw or as group and index
   typedef union packed {
      logic [15:0] raw;
      spr_field_t  fld;
   } spr_addr_u;

   typedef struct packed {
      logic              valid;
      logic              we;
      logic              rfe;
      spr_addr_u         addr;
      logic [DATA_W-1:0] wdata;
   } spr_req_t;

   typedef struct packed {
      logic              illegal;
      logic              align;
      logic              syscall;
      logic              trap;
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] ea;
   } exc_t;

   typedef enum logic [2:0] {NONE, ILLEGAL, ALIGN, SYSCALL, TRAP, INT, TICK} exc_cause_t;

   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] pc;
   } branch_t;

   typedef enum logic [1:0] {IDLE, BRANCH, SETTLE} seq_state_t;

endpackage
